// File: sources.f
+incdir+include
hdl/ebuf_pkg.sv
hdl/ram_2port.sv
hdl/ebuf_ingress.sv
hdl/ebuf_egress.sv
hdl/ebuf_top.sv
verif/ebuf_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the elastic buffer testbench with Verilator
# verdict comes from the fail message in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_TEXT="Simulation finished: FAIL"
PASS_TEXT="Simulation finished: PASS"

verilator --binary --timing --assert -Wno-fatal --top-module ebuf_tb -f sources.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vebuf_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_TEXT" "$LOG"; then
	echo "testbench reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "$PASS_TEXT" "$LOG"; then
	echo "no verdict found in $LOG"
	exit 1
fi
echo "run passed"
exit 0

// File: verif/ebuf_tb.sv
// elastic buffer testbench
// credit-obeying random traffic through ebuf_top
// concurrent assertions check order, latency, back-pressure and credit return

`timescale 1ns/1ps

`include "ebuf_params.svh"

module ebuf_tb;
	import ebuf_pkg::*;

	localparam int SEED = 81504;
	localparam int RESET_CYCLES = 5;
	localparam int QUIET_CYCLES = 8;
	localparam int LAT_WORDS = 4;
	localparam int LAT_GAP = 12;
	localparam int RAND_WORDS = 200;
	// all phases in cycles, plus margin
	localparam int WATCH_CYCLES = RESET_CYCLES + QUIET_CYCLES + LAT_WORDS * (LAT_GAP + 1)
		+ RAND_WORDS * 8 + `EBUF_DEPTH * 16 + 400;

	logic in_clk_ = 1'b0;
	logic in_rst;
	logic up_valid;
	word_t up_data;
	logic up_credit;
	logic dn_valid;
	word_t dn_data;
	logic dn_credit;

	// scoreboard, head mirrored into exp_word
	word_t sb_q[$];
	word_t exp_word;
	int sb_count;
	// sender credits, words seen downstream, credit pulses sent
	int up_credits;
	int dn_count;
	int cred_given;

	// phase flags for the assertions
	logic sent_any;
	logic lat_phase;
	logic hold_phase;
	logic home_check;

	ebuf_top u_dut (
		.in_clk_   (in_clk_),
		.in_rst    (in_rst),
		.up_valid  (up_valid),
		.up_data   (up_data),
		.up_credit (up_credit),
		.dn_valid  (dn_valid),
		.dn_data   (dn_data),
		.dn_credit (dn_credit)
	);

	always #2 in_clk_ = ~in_clk_;

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic refresh_expect();
		sb_count = sb_q.size();
		exp_word = (sb_q.size() != 0) ? sb_q[0] : '0;
	endtask

	// observe mid-cycle, then step to the drive point after the next edge
	task automatic tick();
		logic saw_dn;
		logic saw_up;
		@(negedge in_clk_);
		saw_dn = dn_valid;
		saw_up = up_credit;
		@(posedge in_clk_);
		#1;
		up_valid = 1'b0;
		dn_credit = 1'b0;
		if (saw_dn) begin
			void'(sb_q.pop_front());
			dn_count++;
		end
		if (saw_up) begin
			up_credits++;
		end
		refresh_expect();
	endtask

	task automatic send_word(input word_t w);
		up_valid = 1'b1;
		up_data = w;
		up_credits--;
		sent_any = 1'b1;
		sb_q.push_back(w);
		refresh_expect();
	endtask

	// receiver hands back a credit for a word it already took
	task automatic return_owed();
		if (dn_count > cred_given) begin
			dn_credit = 1'b1;
			cred_given++;
		end
	endtask

	task automatic return_random();
		if ($urandom % 3 == 0) begin
			return_owed();
		end
	endtask

	// empty the buffer and settle every owed credit
	task automatic drain();
		while (sb_q.size() != 0 || dn_count > cred_given) begin
			tick();
			return_owed();
		end
	endtask

	task automatic check_home();
		home_check = 1'b1;
		tick();
		home_check = 1'b0;
	endtask

	// quiet outputs until the first word
	a_quiet: assert property (@(posedge in_clk_) disable iff (in_rst)
		!sent_any |-> !dn_valid && !up_credit)
		else report_error($sformatf("mismatch reset_quiet: expected 0 0, actual %b %b",
			$sampled(dn_valid), $sampled(up_credit)));

	a_order: assert property (@(posedge in_clk_) disable iff (in_rst)
		dn_valid |-> dn_data == exp_word)
		else report_error($sformatf("mismatch ordering: expected %h, actual %h",
			$sampled(exp_word), $sampled(dn_data)));

	a_unsent: assert property (@(posedge in_clk_) disable iff (in_rst)
		dn_valid |-> sb_count != 0)
		else report_error("dn_valid seen with no word outstanding");

	// registered at the second edge after acceptance, sampled at the third
	a_lat_hit: assert property (@(posedge in_clk_) disable iff (in_rst)
		lat_phase && $past(up_valid, 3) |-> dn_valid)
		else report_error($sformatf("mismatch latency: expected dn_valid 1, actual %b",
			$sampled(dn_valid)));

	a_lat_early: assert property (@(posedge in_clk_) disable iff (in_rst)
		lat_phase && !$past(up_valid, 3) |-> !dn_valid)
		else report_error($sformatf("mismatch latency: expected dn_valid 0, actual %b",
			$sampled(dn_valid)));

	a_budget: assert property (@(posedge in_clk_) disable iff (in_rst)
		dn_count + int'(dn_valid) <= `EBUF_DN_CREDITS + cred_given)
		else report_error("more dn_valid cycles than downstream credits granted");

	a_hold: assert property (@(posedge in_clk_) disable iff (in_rst)
		hold_phase |-> !dn_valid)
		else report_error("dn_valid appeared while downstream credits were withheld");

	a_pair: assert property (@(posedge in_clk_) disable iff (in_rst)
		up_credit == dn_valid)
		else report_error($sformatf("mismatch credit_return: expected %b, actual %b",
			$sampled(dn_valid), $sampled(up_credit)));

	a_home: assert property (@(posedge in_clk_) disable iff (in_rst)
		home_check |-> up_credits == `EBUF_DEPTH)
		else report_error($sformatf("mismatch credit_home: expected %0d, actual %0d",
			`EBUF_DEPTH, $sampled(up_credits)));

	// watchdog
	initial begin
		repeat (WATCH_CYCLES) @(posedge in_clk_);
		report_error("timeout: run did not finish within the cycle budget");
	end

	initial begin
		int sent;
		void'($urandom(SEED));
		in_rst = 1'b1;
		up_valid = 1'b0;
		up_data = '0;
		dn_credit = 1'b0;
		up_credits = `EBUF_DEPTH;
		dn_count = 0;
		cred_given = 0;
		sent_any = 1'b0;
		lat_phase = 1'b0;
		hold_phase = 1'b0;
		home_check = 1'b0;
		refresh_expect();
		repeat (RESET_CYCLES) @(posedge in_clk_);
		#1;
		in_rst = 1'b0;

		repeat (QUIET_CYCLES) tick();

		// single words into an empty buffer, credits topped up in between
		lat_phase = 1'b1;
		repeat (LAT_WORDS) begin
			tick();
			send_word(word_t'($urandom));
			repeat (LAT_GAP) begin
				tick();
				return_owed();
			end
		end
		lat_phase = 1'b0;

		// random gaps and random credit return
		sent = 0;
		while (sent < RAND_WORDS) begin
			tick();
			if (up_credits > 0 && $urandom % 4 != 0) begin
				send_word(word_t'($urandom));
				sent++;
			end
			return_random();
		end
		drain();
		check_home();

		// spend the whole downstream budget, return nothing
		repeat (`EBUF_DN_CREDITS) begin
			tick();
			send_word(word_t'($urandom));
		end
		while (dn_count < cred_given + `EBUF_DN_CREDITS) begin
			tick();
		end

		// fill all slots with no credit back
		hold_phase = 1'b1;
		while (up_credits > 0) begin
			tick();
			if ($urandom % 2 == 0) begin
				send_word(word_t'($urandom));
			end
		end
		repeat (10) tick();
		hold_phase = 1'b0;

		// release credits, all 16 words come out in order
		drain();
		check_home();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: hdl/ebuf_top.sv
// elastic buffer top level
// credit-controlled word buffer: ingress writes the ram,
// egress reads it under downstream credit and returns
// upstream credits, all on one clock

`timescale 1ns/1ps

`include "ebuf_params.svh"

module ebuf_top (
	input  logic in_clk_,
	input  logic in_rst,

	// upstream side
	input  logic up_valid,
	input  ebuf_pkg::word_t up_data,
	output logic up_credit,

	// downstream side
	output logic dn_valid,
	output ebuf_pkg::word_t dn_data,
	input  logic dn_credit
);
	import ebuf_pkg::*;

	// ram write port
	logic write_ena;
	addr_t write_addr;
	word_t write_data;

	// ram read port
	logic read_ena;
	addr_t read_addr;
	word_t read_data;

	// ingress pointer for occupancy
	ptr_t wr_ptr;

	ebuf_ingress u_ingress (
		.in_clk_    (in_clk_),
		.in_rst     (in_rst),
		.up_valid   (up_valid),
		.up_data    (up_data),
		.write_ena  (write_ena),
		.write_addr (write_addr),
		.write_data (write_data),
		.wr_ptr     (wr_ptr)
	);

	// simple dual port, both clocks shared
	ram_2port #(
		.NUM_WORDS (`EBUF_DEPTH)
	) u_ram (
		.in_rst     (in_rst),
		.in_clk_1   (in_clk_),
		.write_ena  (write_ena),
		.write_addr (write_addr),
		.write_data (write_data),
		.in_clk_2   (in_clk_),
		.read_ena   (read_ena),
		.read_addr  (read_addr),
		.read_data  (read_data)
	);

	ebuf_egress u_egress (
		.in_clk_   (in_clk_),
		.in_rst    (in_rst),
		.wr_ptr    (wr_ptr),
		.read_ena  (read_ena),
		.read_addr (read_addr),
		.read_data (read_data),
		.dn_valid  (dn_valid),
		.dn_data   (dn_data),
		.dn_credit (dn_credit),
		.up_credit (up_credit)
	);

endmodule

// File: hdl/ebuf_egress.sv
// elastic buffer egress
// works out occupancy from both pointers, spends downstream
// credits on ram reads, presents the returned words downstream
// and hands one upstream credit back per word sent

`timescale 1ns/1ps

`include "ebuf_params.svh"

module ebuf_egress (
	input  logic in_clk_,
	input  logic in_rst,

	// write pointer from ingress
	input  ebuf_pkg::ptr_t wr_ptr,

	// ram read port
	output logic read_ena,
	output ebuf_pkg::addr_t read_addr,
	input  ebuf_pkg::word_t read_data,

	// downstream receiver
	output logic dn_valid,
	output ebuf_pkg::word_t dn_data,
	input  logic dn_credit,

	// credit back to the sender
	output logic up_credit
);
	import ebuf_pkg::*;

	// counter just wide enough for the full budget
	localparam int CRED_BITS = $clog2(`EBUF_DN_CREDITS + 1);

	// next slot to read
	ptr_t rd_ptr;

	// words written but not yet read
	ptr_t occupancy;

	// downstream credits on hand
	logic [CRED_BITS - 1 : 0] credits;

	logic has_word;
	logic issue;

	// marks the cycle the ram register holds a requested word
	logic data_mark;

	assign occupancy = wr_ptr - rd_ptr;
	assign has_word = (occupancy != '0);

	// one read per cycle while a word waits and a credit is left
	assign issue = has_word && (credits != '0);

	// read request register
	always_ff @(posedge in_clk_) begin
		if (in_rst) begin
			rd_ptr <= '0;
			read_ena <= 1'b0;
		end else begin
			read_ena <= issue;
			if (issue) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// address only matters while read_ena is high
	always_ff @(posedge in_clk_) begin
		if (issue) begin
			read_addr <= rd_ptr[`EBUF_ADDR_BITS - 1 : 0];
		end
	end

	// credit counter
	// a spend and a return in one cycle cancel out
	always_ff @(posedge in_clk_) begin
		if (in_rst) begin
			credits <= CRED_BITS'(`EBUF_DN_CREDITS);
		end else begin
			case ({issue, dn_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// one-bit delay line, follows the ram output register
	always_ff @(posedge in_clk_) begin
		if (in_rst) begin
			data_mark <= 1'b0;
		end else begin
			data_mark <= read_ena;
		end
	end

	assign dn_valid = data_mark;
	assign dn_data = read_data;

	// slot is free once its word has left the ram
	assign up_credit = data_mark;

	// more than depth means the sender ignored its credits
	a_occupancy: assert property (@(posedge in_clk_) disable iff (in_rst)
		occupancy <= ptr_t'(`EBUF_DEPTH))
		else $error("ebuf_egress: %0d words stored, sender overran its credits",
			occupancy);

	// receiver returned a credit it never got
	a_credit_limit: assert property (@(posedge in_clk_) disable iff (in_rst)
		credits <= `EBUF_DN_CREDITS)
		else $error("ebuf_egress: downstream credits at %0d, above the budget",
			credits);

endmodule

// File: hdl/ebuf_ingress.sv
// elastic buffer ingress
// takes upstream words and writes each one into the ram
// at the slot picked by the wrapping write pointer

`timescale 1ns/1ps

`include "ebuf_params.svh"

module ebuf_ingress (
	input  logic in_clk_,
	input  logic in_rst,

	// upstream sender
	input  logic up_valid,
	input  ebuf_pkg::word_t up_data,

	// ram write port
	output logic write_ena,
	output ebuf_pkg::addr_t write_addr,
	output ebuf_pkg::word_t write_data,

	// to egress for occupancy
	output ebuf_pkg::ptr_t wr_ptr
);
	import ebuf_pkg::*;

	// wrapping write pointer, one bit above the address
	ptr_t ptr;

	assign wr_ptr = ptr;

	// word lands in the ram on the same edge it is accepted
	assign write_ena = up_valid;
	assign write_data = up_data;

	// low bits select the slot
	assign write_addr = ptr[`EBUF_ADDR_BITS - 1 : 0];

	// advance on every accepted word
	// no full check, the sender's credits keep it in range
	always_ff @(posedge in_clk_) begin
		if (in_rst) begin
			ptr <= '0;
		end else if (up_valid) begin
			ptr <= ptr + 1'b1;
		end
	end

	// sender must present a defined word with valid
	a_data_known: assert property (@(posedge in_clk_) disable iff (in_rst)
		up_valid |-> !$isunknown(up_data))
		else $error("ebuf_ingress: up_data unknown while up_valid is high");

endmodule

// File: hdl/ram_2port.sv
// two-port ram
// port 1 writes, port 2 reads through an output register
// read data is zero when the read is off or out of range

`timescale 1ns/1ps

`include "ebuf_params.svh"

module ram_2port #(
	parameter int NUM_WORDS = `EBUF_DEPTH
) (
	// reset
	input  logic in_rst,

	// port 1, write only
	input  logic in_clk_1,
	input  logic write_ena,
	input  ebuf_pkg::addr_t write_addr,
	input  ebuf_pkg::word_t write_data,

	// port 2, read only
	input  logic in_clk_2,
	input  logic read_ena,
	input  ebuf_pkg::addr_t read_addr,
	output ebuf_pkg::word_t read_data
);
	import ebuf_pkg::*;

	// storage, may be smaller than the address range
	word_t words [0 : NUM_WORDS - 1];

	// port 2 output register
	word_t data_2;

	assign read_data = data_2;

	// port 1 write
	// out of range addresses dropped, nothing written during reset
	always_ff @(posedge in_clk_1) begin
		if (!in_rst && write_ena && write_addr < NUM_WORDS) begin
			words[write_addr] <= write_data;
		end
	end

	// port 2 registered read
	always_ff @(posedge in_clk_2) begin
		if (in_rst) begin
			data_2 <= '0;
		end else if (read_ena && read_addr < NUM_WORDS) begin
			data_2 <= words[read_addr];
		end else begin
			// idle or bad address reads as zero
			data_2 <= '0;
		end
	end

	// reader must stay inside the populated slots
	a_read_range: assert property (@(posedge in_clk_2) disable iff (in_rst)
		read_ena |-> read_addr < NUM_WORDS)
		else $error("ram_2port: read at address %0d beyond %0d words",
			read_addr, NUM_WORDS);

endmodule

// File: hdl/ebuf_pkg.sv
// elastic buffer package
// word, address and pointer types shared by
// the buffer blocks and the testbench

`include "ebuf_params.svh"

package ebuf_pkg;

	// one payload word
	typedef logic [`EBUF_WORD_BITS - 1 : 0] word_t;

	// ram slot address
	typedef logic [`EBUF_ADDR_BITS - 1 : 0] addr_t;

	// wrapping pointer
	// extra msb tells full from empty
	typedef logic [`EBUF_ADDR_BITS : 0] ptr_t;

endpackage

// File: include/ebuf_params.svh
// elastic buffer parameters
// sizes of the word store and the
// credit budgets on both sides

`ifndef EBUF_PARAMS_SVH
`define EBUF_PARAMS_SVH

// ram address width
`define EBUF_ADDR_BITS 4

// payload width
`define EBUF_WORD_BITS 16

// number of slots
// also the credits the sender starts with
`define EBUF_DEPTH (1 << `EBUF_ADDR_BITS)

// credits held towards the receiver after reset
`define EBUF_DN_CREDITS 4

`endif
